//--- hdl/msg_pkg.sv
package msg_pkg;

	// Field widths of one network message
	localparam int ASZ = 6;
	localparam int DSZ = 32;
	localparam int RSZ = 4;

	// Only the low nibble of dat carries the sequence count
	localparam int NSZ = 4;

	// Redundancy widths with addresses zero-extended to a byte first
	localparam int RED_EXT = 8;
	localparam int RED_ADR_NIBS = RED_EXT / RSZ;
	localparam int RED_DAT_NIBS = DSZ / RSZ;

	typedef struct packed {
		logic [ASZ-1:0] src;
		logic [ASZ-1:0] dst;
		logic [DSZ-1:0] dat;
		logic [RSZ-1:0] red;
	} msg_t;

	// leds[0] src0 error, leds[1] src1 error, leds[2] redundancy or unknown src
	typedef struct packed {
		logic [3:0]     leds;
		logic [NSZ-1:0] disp0;
	} dbg_t;

endpackage

//--- hdl/calc_redun.sv
`timescale 1ns/1ps

module calc_redun import msg_pkg::*; (
	input  msg_t           msg,
	output logic [RSZ-1:0] red
);

	logic [RED_EXT-1:0] src_x;
	logic [RED_EXT-1:0] dst_x;
	logic [RSZ-1:0]     acc;

	assign src_x = {{(RED_EXT-ASZ){1'b0}}, msg.src};
	assign dst_x = {{(RED_EXT-ASZ){1'b0}}, msg.dst};

	// XOR of every nibble except the red field itself
	always_comb begin
		acc = '0;
		for (int i = 0; i < RED_ADR_NIBS; i++) begin
			acc = acc ^ src_x[i*RSZ +: RSZ] ^ dst_x[i*RSZ +: RSZ];
		end
		for (int i = 0; i < RED_DAT_NIBS; i++) begin
			acc = acc ^ msg.dat[i*RSZ +: RSZ];
		end
	end

	assign red = acc;

endmodule

//--- hdl/msg_source.sv
`timescale 1ns/1ps

module msg_source import msg_pkg::*; #(
	parameter int SRC_ADDR = 0,
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 1
) (
	input  logic snk0_clk,
	input  logic rst_n,
	output msg_t o_msg,
	output logic o_req,
	input  logic o_ack
);

	typedef enum logic [1:0] {S_DST, S_DAT, S_RED, S_REQ} step_t;

	step_t          step_q;
	logic           req_q;
	logic [ASZ-1:0] dst_q;
	logic [NSZ-1:0] cnt_q;
	logic [NSZ-1:0] nib_q;
	logic [RSZ-1:0] red_q;
	logic [RSZ-1:0] red_calc;
	logic [ASZ-1:0] dst_next;
	logic           idle;
	msg_t           cur_msg;

	assign dst_next = (dst_q >= ASZ'(MAX_ADDR)) ? ASZ'(MIN_ADDR) : dst_q + ASZ'(1);

	// Build only once the previous handshake has fully closed
	assign idle = !req_q && !o_ack;

	assign cur_msg = '{src: ASZ'(SRC_ADDR), dst: dst_q,
		dat: {{(DSZ-NSZ){1'b0}}, nib_q}, red: red_q};

	calc_redun u_red (
		.msg (cur_msg),
		.red (red_calc)
	);

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			step_q <= S_DST;
			req_q <= 1'b0;
			dst_q <= ASZ'(MIN_ADDR);
			cnt_q <= '0;
		end else if (idle) begin
			case (step_q)
				S_DST: begin
					dst_q <= dst_next;
					step_q <= S_DAT;
				end
				S_DAT: begin
					cnt_q <= cnt_q + 1'b1;
					step_q <= S_RED;
				end
				S_RED: step_q <= S_REQ;
				S_REQ: req_q <= 1'b1;
			endcase
		end else if (req_q && o_ack) begin
			req_q <= 1'b0;
			step_q <= S_DST;
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (idle && step_q == S_DAT) begin
			nib_q <= cnt_q;
		end
		if (idle && step_q == S_RED) begin
			red_q <= red_calc;
		end
	end

	assign o_msg = cur_msg;
	assign o_req = req_q;

	// Offered message must hold until the receiver answers
	a_msg_stable: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		(o_req && !o_ack) |=> $stable(o_msg))
		else $error("msg_source %0d changed message while req pending", SRC_ADDR);

endmodule

//--- hdl/msg_checker.sv
`timescale 1ns/1ps

module msg_checker import msg_pkg::*; (
	input  logic snk0_clk,
	input  logic rst_n,
	input  msg_t i_msg,
	input  logic i_req,
	output logic i_ack,
	output dbg_t dbg
);

	typedef enum logic [1:0] {C_CAP, C_RED, C_CHK, C_ACK} step_t;

	step_t                 step_q;
	logic                  ack_q;
	msg_t                  cap_q;
	logic [RSZ-1:0]        red_q;
	logic [RSZ-1:0]        red_calc;
	logic [1:0][NSZ-1:0]   last_q;
	logic [1:0]            src_err_q;
	logic                  bad_q;
	logic [NSZ-1:0]        disp_q;
	logic                  sel;
	logic                  src_known;
	logic [DSZ-1:0]        dat_expect;

	calc_redun u_red (
		.msg (cap_q),
		.red (red_calc)
	);

	assign sel = cap_q.src[0];
	assign src_known = (cap_q.src[ASZ-1:1] == '0);
	assign dat_expect = {{(DSZ-NSZ){1'b0}}, last_q[sel] + 4'd1};

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			step_q <= C_CAP;
			ack_q <= 1'b0;
			last_q <= '1;
			src_err_q <= '0;
			bad_q <= 1'b0;
			disp_q <= '0;
		end else if (i_req && !ack_q) begin
			case (step_q)
				C_CAP: step_q <= C_RED;
				C_RED: step_q <= C_CHK;
				C_CHK: begin
					step_q <= C_ACK;
					if (!src_known) begin
						bad_q <= 1'b1;
					end else if (!src_err_q[sel]) begin
						if (cap_q.red != red_q) begin
							src_err_q[sel] <= 1'b1;
							bad_q <= 1'b1;
						end else if (last_q[sel] <= 4'd14 && cap_q.dat != dat_expect) begin
							src_err_q[sel] <= 1'b1;
						end else begin
							last_q[sel] <= cap_q.dat[NSZ-1:0];
						end
					end
				end
				C_ACK: begin
					disp_q <= cap_q.dat[NSZ-1:0];
					ack_q <= 1'b1;
					step_q <= C_CAP;
				end
			endcase
		end else if (!i_req && ack_q) begin
			ack_q <= 1'b0;
		end
	end

	// Message and recomputed code
	always_ff @(posedge snk0_clk) begin
		if (i_req && !ack_q && step_q == C_CAP) begin
			cap_q <= i_msg;
		end
		if (i_req && !ack_q && step_q == C_RED) begin
			red_q <= red_calc;
		end
	end

	assign i_ack = ack_q;
	assign dbg = '{leds: {1'b0, bad_q, src_err_q[1], src_err_q[0]}, disp0: disp_q};

	a_ack_needs_req: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		$rose(i_ack) |-> i_req)
		else $error("msg_checker raised ack without a pending req");

endmodule

//--- hdl/io_2to1.sv
`timescale 1ns/1ps

module io_2to1 import msg_pkg::*; #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 1
) (
	input  logic snk0_clk,
	input  logic rst_n,
	output msg_t o0_msg,
	output logic o0_req,
	input  logic o0_ack,
	output msg_t o1_msg,
	output logic o1_req,
	input  logic o1_ack,
	input  msg_t i0_msg,
	input  logic i0_req,
	output logic i0_ack,
	output dbg_t dbg
);

	msg_source #(.SRC_ADDR(0), .MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) u_src0 (
		.snk0_clk (snk0_clk),
		.rst_n    (rst_n),
		.o_msg    (o0_msg),
		.o_req    (o0_req),
		.o_ack    (o0_ack)
	);

	msg_source #(.SRC_ADDR(1), .MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) u_src1 (
		.snk0_clk (snk0_clk),
		.rst_n    (rst_n),
		.o_msg    (o1_msg),
		.o_req    (o1_req),
		.o_ack    (o1_ack)
	);

	// Returning stream is checked against both sources
	msg_checker u_snk0 (
		.snk0_clk (snk0_clk),
		.rst_n    (rst_n),
		.i_msg    (i0_msg),
		.i_req    (i0_req),
		.i_ack    (i0_ack),
		.dbg      (dbg)
	);

endmodule

//--- hdl/msg_merge_2to1.sv
`timescale 1ns/1ps

module msg_merge_2to1 import msg_pkg::*; (
	input  logic snk0_clk,
	input  logic rst_n,
	input  msg_t a_msg,
	input  logic a_req,
	output logic a_ack,
	input  msg_t b_msg,
	input  logic b_req,
	output logic b_ack,
	output msg_t y_msg,
	output logic y_req,
	input  logic y_ack
);

	typedef enum logic [1:0] {M_IDLE, M_OFFER, M_DROP} state_t;

	state_t state_q;
	logic   ptr_q;
	logic   gnt_q;
	logic   req_q;
	msg_t   y_msg_q;
	logic   pick_b;
	logic   any_req;
	logic   busy;

	// ptr_q set means input b wins a tie
	assign pick_b = b_req && (!a_req || ptr_q);
	assign any_req = a_req || b_req;
	assign busy = (state_q != M_IDLE);

	always_ff @(posedge snk0_clk) begin
		if (!rst_n) begin
			state_q <= M_IDLE;
			ptr_q <= 1'b0;
			gnt_q <= 1'b0;
			req_q <= 1'b0;
		end else begin
			case (state_q)
				M_IDLE: begin
					if (any_req && !y_ack) begin
						gnt_q <= pick_b;
						ptr_q <= !pick_b;
						req_q <= 1'b1;
						state_q <= M_OFFER;
					end
				end
				M_OFFER: begin
					if (y_ack) begin
						req_q <= 1'b0;
						state_q <= M_DROP;
					end
				end
				M_DROP: begin
					if (!y_ack) begin
						state_q <= M_IDLE;
					end
				end
				default: state_q <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge snk0_clk) begin
		if (state_q == M_IDLE && any_req && !y_ack) begin
			y_msg_q <= pick_b ? b_msg : a_msg;
		end
	end

	assign y_msg = y_msg_q;
	assign y_req = req_q;

	// Output ack mirrored onto the granted input
	assign a_ack = busy && !gnt_q && y_ack;
	assign b_ack = busy && gnt_q && y_ack;

	// Offered message matches what the granted input still holds
	a_fwd_msg: assert property (@(posedge snk0_clk) disable iff (!rst_n)
		(y_req && !y_ack) |-> (y_msg == (gnt_q ? b_msg : a_msg)))
		else $error("msg_merge_2to1 offered a message the granted input no longer holds");

endmodule

//--- hdl/msg_test_node.sv
`timescale 1ns/1ps

module msg_test_node import msg_pkg::*; #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 3
) (
	input  logic snk0_clk,
	input  logic rst_n,
	output msg_t net_out_msg,
	output logic net_out_req,
	input  logic net_out_ack,
	input  msg_t net_in_msg,
	input  logic net_in_req,
	output logic net_in_ack,
	output dbg_t dbg
);

	msg_t o0_msg;
	logic o0_req;
	logic o0_ack;
	msg_t o1_msg;
	logic o1_req;
	logic o1_ack;

	io_2to1 #(.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) u_io (
		.snk0_clk (snk0_clk),
		.rst_n    (rst_n),
		.o0_msg   (o0_msg),
		.o0_req   (o0_req),
		.o0_ack   (o0_ack),
		.o1_msg   (o1_msg),
		.o1_req   (o1_req),
		.o1_ack   (o1_ack),
		.i0_msg   (net_in_msg),
		.i0_req   (net_in_req),
		.i0_ack   (net_in_ack),
		.dbg      (dbg)
	);

	msg_merge_2to1 u_merge (
		.snk0_clk (snk0_clk),
		.rst_n    (rst_n),
		.a_msg    (o0_msg),
		.a_req    (o0_req),
		.a_ack    (o0_ack),
		.b_msg    (o1_msg),
		.b_req    (o1_req),
		.b_ack    (o1_ack),
		.y_msg    (net_out_msg),
		.y_req    (net_out_req),
		.y_ack    (net_out_ack)
	);

endmodule

//--- tests/msg_monitor.sv
`timescale 1ns/1ps

module msg_monitor import msg_pkg::*; #(
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 3
) (
	input  logic       snk0_clk,
	input  logic       rst_n,
	input  msg_t       net_out_msg,
	input  logic       net_out_req,
	input  logic       net_out_ack,
	input  msg_t       net_in_msg,
	input  logic       net_in_req,
	input  logic       net_in_ack,
	input  dbg_t       dbg,
	input  logic       fair_mode,
	input  logic       test_end,
	input  int         test_num,
	input  logic [3:0] exp_leds,
	output int         tests_passed,
	output int         tests_failed,
	output int         total_errs
);

	logic [ASZ-1:0] exp_dst [2];
	logic [3:0]     exp_nib [2];
	logic           out_ack_q = 1'b0;
	logic           in_ack_q = 1'b0;
	logic           have_last = 1'b0;
	logic [ASZ-1:0] last_src = '0;
	logic           have_in = 1'b0;
	logic [3:0]     last_in_nib = '0;
	int             test_errs = 0;
	int             msgs_seen = 0;
	int             n_pass = 0;
	int             n_fail = 0;
	int             n_errs = 0;

	assign tests_passed = n_pass;
	assign tests_failed = n_fail;
	assign total_errs = n_errs;

	// Expected message of a source with red as the XOR of all nibbles
	function automatic msg_t ref_msg(input int src, input logic [ASZ-1:0] dst,
		input logic [3:0] nib);
		msg_t m;
		logic [7:0] s8;
		logic [7:0] d8;
		m.src = ASZ'(src);
		m.dst = dst;
		m.dat = {28'h0, nib};
		s8 = {2'b00, m.src};
		d8 = {2'b00, dst};
		m.red = s8[7:4] ^ s8[3:0] ^ d8[7:4] ^ d8[3:0] ^ nib;
		return m;
	endfunction

	function automatic logic [ASZ-1:0] next_dst(input logic [ASZ-1:0] d);
		if (int'(d) >= MAX_ADDR) begin
			return ASZ'(MIN_ADDR);
		end
		return d + ASZ'(1);
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1: return "clean loopback";
			2: return "fairness";
			3: return "random back-pressure";
			4: return "corruption";
			5: return "gap";
			6: return "display";
			default: return "unknown";
		endcase
	endfunction

	task automatic report_fail(input string msg);
		$display("FAIL at %0d ns: %s", $time, msg);
		test_errs++;
		n_errs++;
	endtask

	task automatic check_out(input msg_t got);
		msg_t want;
		int s;
		s = int'(got.src);
		if (s > 1) begin
			report_fail($sformatf("net_out carries unknown source %0d", s));
		end else begin
			want = ref_msg(s, exp_dst[s], exp_nib[s]);
			if (got !== want) begin
				report_fail($sformatf(
					"src %0d sent dst %0d dat %0h red %0h, expected dst %0d dat %0h red %0h",
					s, got.dst, got.dat, got.red, want.dst, want.dat, want.red));
			end
			if (fair_mode && have_last && got.src == last_src) begin
				report_fail($sformatf("src %0d granted twice in a row", s));
			end
			exp_dst[s] = next_dst(exp_dst[s]);
			exp_nib[s] = exp_nib[s] + 4'd1;
			have_last = 1'b1;
			last_src = got.src;
			msgs_seen++;
		end
	endtask

	always @(posedge snk0_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) begin
				exp_dst[i] = next_dst(ASZ'(MIN_ADDR));
				exp_nib[i] = 4'd0;
			end
			have_last = 1'b0;
			have_in = 1'b0;
			test_errs = 0;
			msgs_seen = 0;
		end else begin
			if (net_out_req && net_out_ack && !out_ack_q) begin
				check_out(net_out_msg);
			end
			// Display follows every accepted delivery
			if (net_in_req && net_in_ack && !in_ack_q) begin
				last_in_nib = net_in_msg.dat[3:0];
				have_in = 1'b1;
				if (dbg.disp0 !== last_in_nib) begin
					report_fail($sformatf("disp0 %0h after delivery of nibble %0h",
						dbg.disp0, last_in_nib));
				end
			end
			if (test_end) begin
				if (dbg.leds !== exp_leds) begin
					report_fail($sformatf("leds %b, expected %b", dbg.leds, exp_leds));
				end
				if (have_in && dbg.disp0 !== last_in_nib) begin
					report_fail($sformatf("final disp0 %0h, expected %0h", dbg.disp0, last_in_nib));
				end
				if (test_errs == 0) begin
					n_pass++;
					$display("ok   test %0d %s, %0d messages", test_num, test_name(test_num),
						msgs_seen);
				end else begin
					n_fail++;
					$display("FAIL at %0d ns: test %0d %s, %0d errors", $time, test_num,
						test_name(test_num), test_errs);
				end
			end
		end
		out_ack_q = net_out_ack;
		in_ack_q = net_in_ack;
	end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/1ps

module tb_top import msg_pkg::*; ();

	localparam int MIN_ADDR = 1;
	localparam int MAX_ADDR = 3;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	localparam int MSGS_PER_TEST = 64;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_MSG = 200;
	localparam int WATCHDOG_NS = MSGS_PER_TEST * NUM_TESTS * CYCLES_PER_MSG * CLK_PERIOD;

	// Delivery modes of the network model
	localparam int M_PASS = 0;
	localparam int M_FLIP = 1;
	localparam int M_DROP = 2;

	logic        snk0_clk;
	logic        rst_n;
	msg_t        net_out_msg;
	logic        net_out_req;
	logic        net_out_ack;
	msg_t        net_in_msg;
	logic        net_in_req;
	logic        net_in_ack;
	dbg_t        dbg;
	logic        fair_mode;
	logic        test_end;
	int          test_num;
	logic [3:0]  exp_leds;
	int          tests_passed;
	int          tests_failed;
	int          total_errs;
	int          model_errs;
	logic [31:0] rng;

	msg_test_node #(.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) uut (
		.snk0_clk    (snk0_clk),
		.rst_n       (rst_n),
		.net_out_msg (net_out_msg),
		.net_out_req (net_out_req),
		.net_out_ack (net_out_ack),
		.net_in_msg  (net_in_msg),
		.net_in_req  (net_in_req),
		.net_in_ack  (net_in_ack),
		.dbg         (dbg)
	);

	msg_monitor #(.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) mon (
		.snk0_clk     (snk0_clk),
		.rst_n        (rst_n),
		.net_out_msg  (net_out_msg),
		.net_out_req  (net_out_req),
		.net_out_ack  (net_out_ack),
		.net_in_msg   (net_in_msg),
		.net_in_req   (net_in_req),
		.net_in_ack   (net_in_ack),
		.dbg          (dbg),
		.fair_mode    (fair_mode),
		.test_end     (test_end),
		.test_num     (test_num),
		.exp_leds     (exp_leds),
		.tests_passed (tests_passed),
		.tests_failed (tests_failed),
		.total_errs   (total_errs)
	);

	initial begin
		snk0_clk = 1'b0;
		forever #(CLK_PERIOD / 2) snk0_clk = ~snk0_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_delay(input int lo, input int hi, output int d);
		rng = xorshift32(rng);
		d = lo + int'(rng % 32'(hi - lo + 1));
	endtask

	// Ack net_out, then loop the message back on net_in
	task automatic serve_msg(input int delay, input int mode, input int tgt_src,
		input int tgt_nib, inout bit armed);
		msg_t m;
		bit hit;
		while (!net_out_req) @(posedge snk0_clk);
		repeat (delay) @(posedge snk0_clk);
		m = net_out_msg;
		net_out_ack <= 1'b1;
		@(posedge snk0_clk);
		while (net_out_req) @(posedge snk0_clk);
		net_out_ack <= 1'b0;
		hit = armed && m.src == ASZ'(tgt_src) && m.dat[3:0] == 4'(tgt_nib);
		if (hit) begin
			armed = 1'b0;
			if (mode == M_FLIP) begin
				m.red[0] = ~m.red[0];
			end
		end
		if (!(hit && mode == M_DROP)) begin
			net_in_msg <= m;
			net_in_req <= 1'b1;
			@(posedge snk0_clk);
			while (!net_in_ack) @(posedge snk0_clk);
			net_in_req <= 1'b0;
			@(posedge snk0_clk);
			while (net_in_ack) @(posedge snk0_clk);
		end
	endtask

	task automatic run_test(input int num, input int lo, input int hi, input logic fair,
		input int mode, input int tgt_src, input int tgt_nib, input logic [3:0] leds);
		bit armed;
		int delay;
		armed = (mode != M_PASS);
		@(posedge snk0_clk);
		test_num <= num;
		fair_mode <= fair;
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge snk0_clk);
		rst_n <= 1'b1;
		for (int i = 0; i < MSGS_PER_TEST; i++) begin
			draw_delay(lo, hi, delay);
			serve_msg(delay, mode, tgt_src, tgt_nib, armed);
		end
		if (armed) begin
			$display("Test %0d never saw the message it was meant to alter", num);
			model_errs++;
		end
		repeat (2) @(posedge snk0_clk);
		exp_leds <= leds;
		test_end <= 1'b1;
		@(posedge snk0_clk);
		test_end <= 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		net_out_ack = 1'b0;
		net_in_msg = '0;
		net_in_req = 1'b0;
		fair_mode = 1'b0;
		test_end = 1'b0;
		test_num = 0;
		exp_leds = 4'b0000;
		model_errs = 0;
		rng = 32'h3100;

		run_test(1, 0, 0, 1'b0, M_PASS, 0, 0, 4'b0000);
		run_test(2, 24, 24, 1'b1, M_PASS, 0, 0, 4'b0000);
		run_test(3, 0, 15, 1'b0, M_PASS, 0, 0, 4'b0000);
		run_test(4, 0, 2, 1'b0, M_FLIP, 1, 6, 4'b0110);
		run_test(5, 0, 2, 1'b0, M_DROP, 0, 5, 4'b0001);
		run_test(6, 0, 6, 1'b0, M_PASS, 0, 0, 4'b0000);

		repeat (2) @(posedge snk0_clk);
		$display("tests %0d, passed %0d, failed %0d, check errors %0d, model errors %0d",
			NUM_TESTS, tests_passed, tests_failed, total_errs, model_errs);
		if (tests_passed == NUM_TESTS && total_errs == 0 && model_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, a handshake never completed", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- sim.f
hdl/msg_pkg.sv
hdl/calc_redun.sv
hdl/msg_source.sv
hdl/msg_checker.sv
hdl/io_2to1.sv
hdl/msg_merge_2to1.sv
hdl/msg_test_node.sv
tests/msg_monitor.sv
tests/tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
